//--- upsize_golden.txt
# T name starts a test. I data keep last dest is one input beat, all fields in hex
# O data keep last dest is the output beat expected next, all fields in hex
T even_packet
I 11111111 f 0 1
I 22222222 f 0 1
I 33333333 f 0 1
I 44444444 f 1 1
O 1111111122222222 ff 0 1
O 3333333344444444 ff 1 1
T odd_packet
I 01020304 f 0 3
I 05060708 f 0 3
I 090a0b0c c 1 3
O 0102030405060708 ff 0 3
O 090a0b0c00000000 c0 1 3
T dest_latch
I c0de0001 f 0 5
I c0de0002 f 0 9
I c0de0003 f 0 a
I c0de0004 f 1 b
O c0de0001c0de0002 ff 0 5
O c0de0003c0de0004 ff 1 5
T lane_order
I 0000a001 f 1 6
I 0000b001 f 0 7
I 0000b002 f 0 7
I 0000b003 3 1 7
I 0000d001 f 0 9
I 0000d002 f 1 9
O 0000a00100000000 f0 1 6
O 0000b0010000b002 ff 0 7
O 0000b00300000000 30 1 7
O 0000d0010000d002 ff 1 9

//--- flist.f
axis_cfg_pkg.sv
axis_types_pkg.sv
axis_if.sv
pkt_dispatcher.sv
width_upsizer.sv
pkt_merger.sv
upsize_array.sv
upsize_array_props.sv
tb_upsize_array.sv

//--- tb_upsize_array.sv
// Upsizer array testbench
`timescale 1ns/1ns
`default_nettype none

module tb_upsize_array
    import axis_types_pkg::*;
();

    localparam int SEED      = 6;
    localparam int TIMEOUT   = 2000;
    localparam int STALL_PCT = 30;
    localparam int GAP_PCT   = 25;

    logic         from_tx;
    logic         rst_n;
    logic         in_valid;
    logic         in_ready;
    narrow_data_t in_data;
    narrow_keep_t in_keep;
    logic         in_last;
    dest_t        in_dest;
    logic         out_valid;
    logic         out_ready;
    wide_data_t   out_data;
    wide_keep_t   out_keep;
    logic         out_last;
    dest_t        out_dest;

    string        test_names[$];
    narrow_data_t src_data[$];
    narrow_keep_t src_keep[$];
    logic         src_last[$];
    dest_t        src_dest[$];
    int           src_gap[$];
    wide_data_t   exp_data[$];
    wide_keep_t   exp_keep[$];
    logic         exp_last[$];
    dest_t        exp_dest[$];
    int           exp_test[$];

    int           errors;
    int           tests_pass;
    int           tests_fail;
    bit           timed_out;

    upsize_array dut (.*);

    initial begin
        from_tx = 1'b0;
        forever #5 from_tx = ~from_tx;
    end

    task automatic read_golden();
        int          fd;
        string       line;
        string       name;
        logic [63:0] d;
        logic [7:0]  k;
        logic        l;
        logic [3:0]  t;
        fd = $fopen("upsize_golden.txt", "r");
        if (fd == 0) begin
            $display("Could not open upsize_golden.txt");
            errors++;
            return;
        end
        while ($fgets(line, fd) > 0) begin
            if (line[0] == "T" && $sscanf(line, "T %s", name) == 1) begin
                test_names.push_back(name);
            end else if (line[0] == "I" && $sscanf(line, "I %h %h %h %h", d, k, l, t) == 4) begin
                src_data.push_back(narrow_data_t'(d));
                src_keep.push_back(narrow_keep_t'(k));
                src_last.push_back(l);
                src_dest.push_back(t);
                // Some beats are preceded by a short idle gap
                src_gap.push_back(($urandom_range(99) < GAP_PCT) ? $urandom_range(3, 1) : 0);
            end else if (line[0] == "O" && $sscanf(line, "O %h %h %h %h", d, k, l, t) == 4) begin
                exp_data.push_back(d);
                exp_keep.push_back(k);
                exp_last.push_back(l);
                exp_dest.push_back(t);
                exp_test.push_back(test_names.size() - 1);
            end
        end
        $fclose(fd);
        if (exp_data.size() == 0) begin
            $display("The golden file holds no expected output beats");
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errs);
        if (errs == 0) begin
            tests_pass++;
            $display("test %s: passed", name);
        end else begin
            tests_fail++;
            $display("test %s: failed with %0d errors", name, errs);
        end
    endtask

    task automatic check_idle(input string phase);
        if (out_valid !== 1'b0 || in_ready !== 1'b1) begin
            $display("[FAIL] %0t: %s, out_valid=%b in_ready=%b",
                     $time, phase, out_valid, in_ready);
            errors++;
        end
    endtask

    task automatic drive_input();
        int wait_cnt;
        bit accepted;
        for (int i = 0; i < src_data.size() && !timed_out; i++) begin
            repeat (src_gap[i]) begin
                @(posedge from_tx);
                #1;
            end
            in_valid = 1'b1;
            in_data  = src_data[i];
            in_keep  = src_keep[i];
            in_last  = src_last[i];
            in_dest  = src_dest[i];
            accepted = 1'b0;
            wait_cnt = 0;
            // The beat transfers on the edge that follows a high in_ready
            while (!accepted && !timed_out) begin
                @(negedge from_tx);
                accepted = in_ready;
                @(posedge from_tx);
                #1;
                wait_cnt++;
                if (!accepted && wait_cnt >= TIMEOUT) begin
                    $display("Timeout: input beat %0d was not accepted in %0d cycles", i, TIMEOUT);
                    errors++;
                    timed_out = 1'b1;
                end
            end
            in_valid = 1'b0;
        end
    endtask

    task automatic monitor_output();
        int idx;
        int idle;
        int cur_errs;
        idx = 0;
        idle = 0;
        cur_errs = 0;
        while (idx < exp_data.size() && !timed_out) begin
            out_ready = ($urandom_range(99) >= STALL_PCT);
            @(negedge from_tx);
            if (out_valid && out_ready) begin
                if (out_data !== exp_data[idx] || out_keep !== exp_keep[idx] ||
                    out_last !== exp_last[idx] || out_dest !== exp_dest[idx]) begin
                    $display("[FAIL] %0t: word %0d got %h %h %b %h, expected %h %h %b %h",
                             $time, idx, out_data, out_keep, out_last, out_dest,
                             exp_data[idx], exp_keep[idx], exp_last[idx], exp_dest[idx]);
                    errors++;
                    cur_errs++;
                end
                if (idx + 1 == exp_data.size() || exp_test[idx + 1] != exp_test[idx]) begin
                    report_test(test_names[exp_test[idx]], cur_errs);
                    cur_errs = 0;
                end
                idx++;
                idle = 0;
            end else begin
                idle++;
                if (idle >= TIMEOUT) begin
                    $display("Timeout: output word %0d did not arrive in %0d cycles", idx, TIMEOUT);
                    errors++;
                    timed_out = 1'b1;
                end
            end
            @(posedge from_tx);
            #1;
        end
    endtask

    initial begin
        int seed_ret;
        int reset_errs;
        seed_ret   = $urandom(SEED);
        errors     = 0;
        tests_pass = 0;
        tests_fail = 0;
        timed_out  = 1'b0;
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        in_data    = '0;
        in_keep    = '0;
        in_last    = 1'b0;
        in_dest    = '0;
        out_ready  = 1'b0;
        read_golden();

        reset_errs = errors;
        repeat (5) begin
            @(negedge from_tx);
            check_idle("during reset");
        end
        @(posedge from_tx);
        #1;
        rst_n = 1'b1;
        @(negedge from_tx);
        check_idle("first cycle after reset");
        report_test("reset", errors - reset_errs);

        @(posedge from_tx);
        #1;
        fork
            drive_input();
            monitor_output();
        join

        // Any word after the last expected one is a duplicate
        if (!timed_out) begin
            out_ready = 1'b1;
            repeat (10) begin
                @(negedge from_tx);
                if (out_valid) begin
                    $display("[FAIL] %0t: unexpected extra output word %h", $time, out_data);
                    errors++;
                end
            end
        end

        // Handshake rule violations seen by the bound checker
        if (dut.u_props.fail_count != 0) begin
            $display("The handshake checker saw %0d rule violations", dut.u_props.fail_count);
            errors += dut.u_props.fail_count;
        end

        tests_fail = test_names.size() + 1 - tests_pass;
        $display("Tests passed: %0d, failed: %0d, errors: %0d", tests_pass, tests_fail, errors);
        if (errors == 0 && tests_fail == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- upsize_array_props.sv
// Top-level stream handshake checks
`timescale 1ns/1ns
`default_nettype none

module upsize_array_props
    import axis_types_pkg::*;
(
    input logic         from_tx,
    input logic         rst_n,
    input logic         in_valid,
    input logic         in_ready,
    input narrow_data_t in_data,
    input narrow_keep_t in_keep,
    input logic         in_last,
    input dest_t        in_dest,
    input logic         out_valid,
    input logic         out_ready,
    input wide_data_t   out_data,
    input wide_keep_t   out_keep,
    input logic         out_last,
    input dest_t        out_dest
);

    // Number of failed handshake checks so far
    int fail_count = 0;

    // Nothing leaves the array while reset is held
    out_idle_in_reset: assert property (@(posedge from_tx) !rst_n |-> !out_valid)
        else begin
            $error("out_valid is high during reset");
            fail_count++;
        end

    // A word offered to a stalled sink stays put until it is taken
    out_hold_on_stall: assert property (@(posedge from_tx) disable iff (!rst_n)
        out_valid && !out_ready |=>
        out_valid && $stable({out_data, out_keep, out_last, out_dest}))
        else begin
            $error("output word changed while stalled");
            fail_count++;
        end

    in_hold_on_stall: assert property (@(posedge from_tx) disable iff (!rst_n)
        in_valid && !in_ready |=>
        in_valid && $stable({in_data, in_keep, in_last, in_dest}))
        else begin
            $error("input beat changed while stalled");
            fail_count++;
        end

endmodule

bind upsize_array upsize_array_props u_props (.*);

`default_nettype wire

//--- upsize_array.sv
// Two-lane stream upsizer top
`timescale 1ns/1ns
`default_nettype none

module upsize_array
    import axis_cfg_pkg::*;
    import axis_types_pkg::*;
(
    input  logic         from_tx,
    input  logic         rst_n,

    input  logic         in_valid,
    output logic         in_ready,
    input  narrow_data_t in_data,
    input  narrow_keep_t in_keep,
    input  logic         in_last,
    input  dest_t        in_dest,

    output logic         out_valid,
    input  logic         out_ready,
    output wide_data_t   out_data,
    output wide_keep_t   out_keep,
    output logic         out_last,
    output dest_t        out_dest
);

    axis_if #(.BYTES(NARROW_BYTES)) in_if ();
    axis_if #(.BYTES(NARROW_BYTES)) narrow_if [NUM_LANES] ();
    axis_if #(.BYTES(WIDE_BYTES))   wide_if [NUM_LANES] ();
    axis_if #(.BYTES(WIDE_BYTES))   out_if ();

    assign in_if.valid = in_valid;
    assign in_if.data  = in_data;
    assign in_if.keep  = in_keep;
    assign in_if.last  = in_last;
    assign in_if.dest  = in_dest;
    assign in_ready    = in_if.ready;

    pkt_dispatcher u_dispatcher (
        .from_tx (from_tx),
        .rst_n   (rst_n),
        .src     (in_if),
        .lanes   (narrow_if)
    );

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        width_upsizer u_upsizer (
            .from_tx (from_tx),
            .rst_n   (rst_n),
            .src     (narrow_if[i]),
            .snk     (wide_if[i])
        );
    end

    pkt_merger u_merger (
        .from_tx (from_tx),
        .rst_n   (rst_n),
        .lanes   (wide_if),
        .snk     (out_if)
    );

    assign out_valid    = out_if.valid;
    assign out_data     = out_if.data;
    assign out_keep     = out_if.keep;
    assign out_last     = out_if.last;
    assign out_dest     = out_if.dest;
    assign out_if.ready = out_ready;

endmodule

`default_nettype wire

//--- pkt_merger.sv
// Round-robin packet merger
`timescale 1ns/1ns
`default_nettype none

module pkt_merger
    import axis_cfg_pkg::*;
    import axis_types_pkg::*;
(
    input  logic from_tx,
    input  logic rst_n,
    axis_if.rx   lanes [NUM_LANES],
    axis_if.tx   snk
);

    lane_idx_t              ptr;
    logic [NUM_LANES-1:0]   lane_valid;
    logic [NUM_LANES-1:0]   lane_last;
    wide_data_t             lane_data [NUM_LANES];
    wide_keep_t             lane_keep [NUM_LANES];
    dest_t                  lane_dest [NUM_LANES];
    logic                   pkt_end;

    // Gather the lane fields so the pointer can select among them
    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        assign lane_valid[i] = lanes[i].valid;
        assign lane_last[i]  = lanes[i].last;
        assign lane_data[i]  = lanes[i].data;
        assign lane_keep[i]  = lanes[i].keep;
        assign lane_dest[i]  = lanes[i].dest;
        // Lanes other than the current one wait their turn
        assign lanes[i].ready = snk.ready && (ptr == lane_idx_t'(i));
    end

    assign snk.valid = lane_valid[ptr];
    assign snk.data  = lane_data[ptr];
    assign snk.keep  = lane_keep[ptr];
    assign snk.last  = lane_last[ptr];
    assign snk.dest  = lane_dest[ptr];

    assign pkt_end = snk.valid && snk.ready && snk.last;

    // Same lane order as the dispatcher, so packets leave in arrival order
    always_ff @(posedge from_tx or negedge rst_n) begin
        if (!rst_n) begin
            ptr <= '0;
        end else if (pkt_end) begin
            ptr <= next_lane(ptr);
        end
    end

endmodule

`default_nettype wire

//--- width_upsizer.sv
// Narrow to wide stream packer
`timescale 1ns/1ns
`default_nettype none

module width_upsizer
    import axis_cfg_pkg::*;
    import axis_types_pkg::*;
(
    input  logic from_tx,
    input  logic rst_n,
    axis_if.rx   src,
    axis_if.tx   snk
);

    typedef logic [$clog2(PACK_RATIO)-1:0] slot_t;

    beat_cnt_t                      cnt;
    beat_cnt_t                      wr_cnt;
    slot_t                          wr_slot;
    logic                           sop_q;
    logic                           last_q;
    dest_t                          dest_q;
    narrow_data_t [PACK_RATIO-1:0]  data_q;
    narrow_keep_t [PACK_RATIO-1:0]  keep_q;
    logic                           in_fire;
    logic                           out_fire;

    assign in_fire  = src.valid && src.ready;
    assign out_fire = snk.valid && snk.ready;

    // The word is ready when full, or early when the packet has ended
    assign snk.valid = (cnt == beat_cnt_t'(PACK_RATIO)) || ((cnt != '0) && last_q);

    // Accept while the word is not complete, or while it is leaving
    assign src.ready = snk.ready || !snk.valid;

    // A word that leaves this cycle frees the register for a fresh fill
    always_comb begin
        wr_cnt = out_fire ? '0 : cnt;
        if (PACK_MSB_FIRST) begin
            wr_slot = slot_t'(PACK_RATIO - 1 - int'(wr_cnt));
        end else begin
            wr_slot = slot_t'(wr_cnt);
        end
    end

    always_ff @(posedge from_tx or negedge rst_n) begin
        if (!rst_n) begin
            cnt   <= '0;
            sop_q <= 1'b1;
        end else begin
            if (in_fire) begin
                cnt   <= wr_cnt + 1'b1;
                // The beat after a last starts a new packet
                sop_q <= src.last;
            end else if (out_fire) begin
                cnt <= '0;
            end
        end
    end

    always_ff @(posedge from_tx) begin
        if (in_fire) begin
            // Starting a word clears the slots a short packet leaves empty
            if (wr_cnt == '0) begin
                data_q <= '0;
                keep_q <= '0;
            end
            data_q[wr_slot] <= src.data;
            keep_q[wr_slot] <= src.keep;
            last_q          <= src.last;
            if (sop_q || !DEST_ON_SOP) begin
                dest_q <= src.dest;
            end
        end
    end

    assign snk.data = data_q;
    assign snk.keep = keep_q;
    assign snk.last = last_q;
    // Dest holds for every word of the packet
    assign snk.dest = dest_q;

endmodule

`default_nettype wire

//--- pkt_dispatcher.sv
// Round-robin packet dispatcher
`timescale 1ns/1ns
`default_nettype none

module pkt_dispatcher
    import axis_cfg_pkg::*;
(
    input  logic from_tx,
    input  logic rst_n,
    axis_if.rx   src,
    axis_if.tx   lanes [NUM_LANES]
);

    lane_idx_t              ptr;
    logic [NUM_LANES-1:0]   lane_ready;
    logic                   pkt_end;

    // Only the selected lane sees valid, the payload is broadcast to all lanes
    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        assign lanes[i].valid = src.valid && (ptr == lane_idx_t'(i));
        assign lanes[i].data  = src.data;
        assign lanes[i].keep  = src.keep;
        assign lanes[i].last  = src.last;
        assign lanes[i].dest  = src.dest;
        assign lane_ready[i]  = lanes[i].ready;
    end

    // A stalled lane stalls the whole input
    assign src.ready = lane_ready[ptr];

    assign pkt_end = src.valid && src.ready && src.last;

    // Move on to the next lane once the whole packet has gone through
    always_ff @(posedge from_tx or negedge rst_n) begin
        if (!rst_n) begin
            ptr <= '0;
        end else if (pkt_end) begin
            ptr <= next_lane(ptr);
        end
    end

endmodule

`default_nettype wire

//--- axis_if.sv
// Stream interface
`timescale 1ns/1ns
`default_nettype none

interface axis_if
    import axis_types_pkg::*;
#(
    parameter int BYTES = 4
);

    logic               valid;
    logic               ready;
    logic [BYTES*8-1:0] data;
    logic [BYTES-1:0]   keep;
    logic               last;
    dest_t              dest;

    // A beat moves on a rising edge with valid and ready both high
    modport tx (
        output valid, data, keep, last, dest,
        input  ready
    );

    modport rx (
        input  valid, data, keep, last, dest,
        output ready
    );

endinterface

`default_nettype wire

//--- axis_types_pkg.sv
// Stream field types
`default_nettype none

package axis_types_pkg;

    import axis_cfg_pkg::*;

    // Width of the per-packet routing tag
    localparam int DEST_BITS = 4;

    // Narrow side carries one input beat of NARROW_BYTES
    typedef logic [NARROW_BYTES*8-1:0] narrow_data_t;
    typedef logic [NARROW_BYTES-1:0]   narrow_keep_t;

    // Wide side carries PACK_RATIO narrow beats side by side
    typedef logic [WIDE_BYTES*8-1:0]   wide_data_t;
    typedef logic [WIDE_BYTES-1:0]     wide_keep_t;

    // Destination tag, identical on both sides
    typedef logic [DEST_BITS-1:0]      dest_t;

endpackage

`default_nettype wire

//--- axis_cfg_pkg.sv
// Upsizer subsystem configuration
`default_nettype none

package axis_cfg_pkg;

    localparam int NARROW_BYTES = 4;
    localparam int WIDE_BYTES   = 8;
    localparam int PACK_RATIO   = WIDE_BYTES / NARROW_BYTES;
    localparam int NUM_LANES    = 2;

    // First accepted beat lands in the most significant slot of the word
    localparam bit PACK_MSB_FIRST = 1'b1;

    // Dest is captured from the first beat of a packet only
    localparam bit DEST_ON_SOP = 1'b1;

    typedef logic [$clog2(NUM_LANES)-1:0]    lane_idx_t;
    typedef logic [$clog2(PACK_RATIO+1)-1:0] beat_cnt_t;

    // Round-robin step shared by the dispatcher and the merger
    function automatic lane_idx_t next_lane(input lane_idx_t lane);
        return (lane == lane_idx_t'(NUM_LANES - 1)) ? '0 : lane + 1'b1;
    endfunction

endpackage

`default_nettype wire
